// File: common/cache_pkg.sv
package cache_pkg;

  // ========================================
  // widths and payload types
  // ========================================
  localparam int word_bits = 32;              // data word
  localparam int addr_bits = 32;              // byte address

  typedef logic [word_bits-1:0] word_t;
  typedef logic [addr_bits-1:0] addr_t;

  // ========================================
  // request kind, same on proc and mem ports
  // ========================================
  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_type_e;

  // ========================================
  // controller states
  // ========================================
  typedef enum logic [2:0] {
    st_tag_check  = 3'd0,                     // idle, lookup of incoming request
    st_respond    = 3'd1,                     // memresp_val held until taken
    st_evict      = 3'd2,                     // victim line written back word by word
    st_refill     = 3'd3,                     // line fetched word by word
    st_flush_scan = 3'd4,                     // walking lines for flush
    st_flush_wait = 3'd5                      // flush_done high until flush drops
  } ctrl_state_e;

endpackage

// File: cache/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int num_lines      = 8,
  parameter int words_per_line = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic flush,                         // level, held until flush_done seen
  output logic flush_done,

  // processor port handshakes
  input  logic memreq_val,
  output logic memreq_rdy,
  output logic memresp_val,
  input  logic memresp_rdy,

  // memory port handshakes
  output logic cache_req_val,
  input  logic cache_req_rdy,
  input  logic cache_resp_val,
  output logic cache_resp_rdy,

  // status from datapath
  input  logic tag_match,                     // hit at the looked-up line
  input  logic victim_dirty,                  // addressed line valid and dirty
  input  logic line_dirty,                    // dirty bit at flush_line
  input  logic req_is_write,

  // datapath enables and selects
  output logic req_en,                        // capture incoming request
  output logic tag_w_en,                      // install tag, set valid, clear dirty
  output logic data_w_en,
  output logic data_w_sel,                    // 1 = processor word, 0 = refill word
  output logic dirty_set,
  output logic dirty_clr,
  output logic addr_sel,                      // 1 = flush line, 0 = request line
  output logic [$clog2(words_per_line)-1:0] word_cnt,
  output logic [$clog2(num_lines)-1:0]      flush_line,
  output logic cache_req_write                // mem request is a writeback
);

  localparam int wb = $clog2(words_per_line);
  localparam int lb = $clog2(num_lines);

  cache_pkg::ctrl_state_e state;

  logic flushing;                             // evict belongs to a flush scan
  logic merge;                                // write word merge after refill
  logic resp_fire;
  logic last_word;
  logic last_line;
  logic wr_hit;
  logic refill_w;

  // ========================================
  // datapath controls
  // ========================================
  assign resp_fire = cache_resp_val && cache_resp_rdy;
  assign last_word = word_cnt == wb'(words_per_line - 1);
  assign last_line = flush_line == lb'(num_lines - 1);

  assign req_en   = (state == cache_pkg::st_tag_check) && memreq_val && memreq_rdy;
  assign wr_hit   = req_en && tag_match && req_is_write;
  assign refill_w = (state == cache_pkg::st_refill) && resp_fire;

  assign tag_w_en   = refill_w && last_word;  // line complete
  assign data_w_en  = wr_hit || refill_w || merge;
  assign data_w_sel = wr_hit || merge;
  assign dirty_set  = wr_hit || merge;
  assign dirty_clr  = (state == cache_pkg::st_evict) && flushing && resp_fire && last_word;
  assign addr_sel   = flushing;

  assign cache_req_write = state == cache_pkg::st_evict;

  // ========================================
  // state and registered handshakes
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= cache_pkg::st_tag_check;
      word_cnt       <= '0;
      flush_line     <= '0;
      flushing       <= 1'b0;
      merge          <= 1'b0;
      memreq_rdy     <= 1'b0;
      memresp_val    <= 1'b0;
      cache_req_val  <= 1'b0;
      cache_resp_rdy <= 1'b0;
      flush_done     <= 1'b0;
    end else begin
      case (state)
        cache_pkg::st_tag_check: begin
          if (req_en) begin                   // request wins over flush
            memreq_rdy <= 1'b0;
            if (tag_match) begin
              state       <= cache_pkg::st_respond;
              memresp_val <= 1'b1;
            end else begin
              state         <= victim_dirty ? cache_pkg::st_evict : cache_pkg::st_refill;
              cache_req_val <= 1'b1;          // first word goes out next cycle
            end
          end else if (flush) begin
            memreq_rdy <= 1'b0;
            state      <= cache_pkg::st_flush_scan;
            flushing   <= 1'b1;
            flush_line <= '0;
          end else begin
            memreq_rdy <= 1'b1;
          end
        end

        cache_pkg::st_respond: begin
          if (memresp_rdy) begin
            memresp_val <= 1'b0;
            memreq_rdy  <= !flush;
            state       <= cache_pkg::st_tag_check;
          end
        end

        cache_pkg::st_evict, cache_pkg::st_refill: begin
          if (cache_req_val && cache_req_rdy) begin
            cache_req_val  <= 1'b0;           // one word in flight
            cache_resp_rdy <= 1'b1;
          end
          if (resp_fire) begin
            cache_resp_rdy <= 1'b0;
            if (!last_word) begin
              word_cnt      <= word_cnt + 1'b1;
              cache_req_val <= 1'b1;
            end else begin
              word_cnt <= '0;
              if (state == cache_pkg::st_refill) begin
                if (req_is_write) begin
                  merge <= 1'b1;              // store word next cycle
                end else begin
                  state       <= cache_pkg::st_respond;
                  memresp_val <= 1'b1;
                end
              end else if (!flushing) begin
                state         <= cache_pkg::st_refill;
                cache_req_val <= 1'b1;
              end else if (last_line) begin
                state      <= cache_pkg::st_flush_wait;
                flushing   <= 1'b0;
                flush_done <= 1'b1;
              end else begin
                flush_line <= flush_line + 1'b1;
                state      <= cache_pkg::st_flush_scan;
              end
            end
          end
          if (merge) begin
            merge       <= 1'b0;
            state       <= cache_pkg::st_respond;
            memresp_val <= 1'b1;
          end
        end

        cache_pkg::st_flush_scan: begin
          if (line_dirty) begin
            state         <= cache_pkg::st_evict;
            cache_req_val <= 1'b1;
          end else if (last_line) begin
            state      <= cache_pkg::st_flush_wait;
            flushing   <= 1'b0;
            flush_done <= 1'b1;
          end else begin
            flush_line <= flush_line + 1'b1;  // clean line, one cycle
          end
        end

        cache_pkg::st_flush_wait: begin
          if (!flush) begin
            state      <= cache_pkg::st_tag_check;
            flush_done <= 1'b0;
            memreq_rdy <= 1'b1;
          end
        end

        default: state <= cache_pkg::st_tag_check;
      endcase
    end
  end

  // ========================================
  // protocol checks
  // ========================================
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val);

  a_no_mem_req: assert property (@(posedge clk) disable iff (reset)
    state inside {cache_pkg::st_tag_check, cache_pkg::st_respond} |-> !cache_req_val);

  a_flush_done: assert property (@(posedge clk) disable iff (reset)
    flush_done |-> state == cache_pkg::st_flush_wait);

endmodule

// File: cache/cache_dpath.sv
`timescale 1ns/10ps

module cache_dpath #(
  parameter int num_lines      = 8,
  parameter int words_per_line = 4
) (
  input  logic clk,
  input  logic reset,

  // processor request payload
  input  cache_pkg::req_type_e memreq_type,
  input  cache_pkg::addr_t     memreq_addr,
  input  cache_pkg::word_t     memreq_data,
  input  cache_pkg::word_t     cache_resp_data,

  // controls from the controller
  input  logic req_en,
  input  logic tag_w_en,
  input  logic data_w_en,
  input  logic data_w_sel,
  input  logic dirty_set,
  input  logic dirty_clr,
  input  logic addr_sel,
  input  logic cache_req_write,
  input  logic [$clog2(words_per_line)-1:0] word_cnt,
  input  logic [$clog2(num_lines)-1:0]      flush_line,

  // status and payload out
  output logic tag_match,
  output logic victim_dirty,
  output logic line_dirty,
  output logic req_is_write,
  output cache_pkg::word_t memresp_data,
  output cache_pkg::addr_t cache_req_addr,
  output cache_pkg::word_t cache_req_data
);

  localparam int off_bits = $clog2(cache_pkg::word_bits / 8);
  localparam int wb       = $clog2(words_per_line);
  localparam int lb       = $clog2(num_lines);
  localparam int tag_bits = cache_pkg::addr_bits - off_bits - wb - lb;

  // accepted request
  cache_pkg::req_type_e req_type_q;
  cache_pkg::addr_t     req_addr_q;
  cache_pkg::word_t     req_data_q;

  // current request, straight from the port during lookup
  cache_pkg::req_type_e cur_type;
  cache_pkg::addr_t     cur_addr;
  cache_pkg::word_t     cur_data;
  logic [wb-1:0]        cur_word;
  logic [lb-1:0]        cur_idx;
  logic [tag_bits-1:0]  cur_tag;

  // arrays
  logic [tag_bits-1:0]  tag_array [num_lines];
  logic [num_lines-1:0] valid;
  logic [num_lines-1:0] dirty;
  cache_pkg::word_t     data_array [num_lines*words_per_line];

  logic [lb-1:0]        line_sel;             // line for mem side and dirty clear
  logic [wb+lb-1:0]     w_ptr;
  cache_pkg::word_t     w_data;

  // ========================================
  // request select and address fields
  // ========================================
  assign cur_type = req_en ? memreq_type : req_type_q;
  assign cur_addr = req_en ? memreq_addr : req_addr_q;
  assign cur_data = req_en ? memreq_data : req_data_q;

  assign cur_word = cur_addr[off_bits +: wb];
  assign cur_idx  = cur_addr[off_bits + wb +: lb];
  assign cur_tag  = cur_addr[cache_pkg::addr_bits-1 -: tag_bits];

  assign req_is_write = cur_type == cache_pkg::req_write;

  always_ff @(posedge clk) begin
    if (req_en) begin
      req_type_q <= memreq_type;
      req_addr_q <= memreq_addr;
      req_data_q <= memreq_data;
    end
  end

  // ========================================
  // lookup
  // ========================================
  assign tag_match    = valid[cur_idx] && (tag_array[cur_idx] == cur_tag);
  assign victim_dirty = valid[cur_idx] && dirty[cur_idx];
  assign line_dirty   = dirty[flush_line];

  // ========================================
  // memory side address and data
  // ========================================
  assign line_sel = addr_sel ? flush_line : cur_idx;

  // writeback uses stored tag, refill the request tag
  assign cache_req_addr = {cache_req_write ? tag_array[line_sel] : cur_tag,
                           line_sel, word_cnt, off_bits'(0)};
  assign cache_req_data = data_array[{line_sel, word_cnt}];

  // ========================================
  // array updates
  // ========================================
  assign w_ptr  = data_w_sel ? {cur_idx, cur_word} : {line_sel, word_cnt};
  assign w_data = data_w_sel ? cur_data : cache_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (tag_w_en) begin
        valid[cur_idx] <= 1'b1;
        dirty[cur_idx] <= 1'b0;               // fresh line is clean
      end
      if (dirty_set) dirty[cur_idx] <= 1'b1;
      if (dirty_clr) dirty[line_sel] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_w_en) tag_array[cur_idx] <= cur_tag;
    if (data_w_en) data_array[w_ptr] <= w_data;
  end

  // response word: hit read at lookup, else word written to the requested slot
  always_ff @(posedge clk) begin
    if (req_en) begin
      memresp_data <= data_array[{cur_idx, cur_word}];
    end else if (data_w_en && (w_ptr == {cur_idx, cur_word})) begin
      memresp_data <= w_data;
    end
  end

  // a lookup cycle writes the array only on a write hit
  a_lookup_write: assert property (@(posedge clk) disable iff (reset)
    data_w_en && req_en |-> tag_match && req_is_write);

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
  parameter int num_lines      = 8,
  parameter int words_per_line = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic flush,
  output logic flush_done,

  // processor port
  input  logic                 memreq_val,
  output logic                 memreq_rdy,
  input  cache_pkg::req_type_e memreq_type,
  input  cache_pkg::addr_t     memreq_addr,
  input  cache_pkg::word_t     memreq_data,
  output logic                 memresp_val,
  input  logic                 memresp_rdy,
  output cache_pkg::word_t     memresp_data,

  // memory port
  output logic                 cache_req_val,
  input  logic                 cache_req_rdy,
  output cache_pkg::req_type_e cache_req_type,
  output cache_pkg::addr_t     cache_req_addr,
  output cache_pkg::word_t     cache_req_data,
  input  logic                 cache_resp_val,
  output logic                 cache_resp_rdy,
  input  cache_pkg::word_t     cache_resp_data
);

  // controller to datapath
  logic req_en;
  logic tag_w_en;
  logic data_w_en;
  logic data_w_sel;
  logic dirty_set;
  logic dirty_clr;
  logic addr_sel;
  logic cache_req_write;
  logic [$clog2(words_per_line)-1:0] word_cnt;
  logic [$clog2(num_lines)-1:0]      flush_line;

  // datapath to controller
  logic tag_match;
  logic victim_dirty;
  logic line_dirty;
  logic req_is_write;

  assign cache_req_type = cache_pkg::req_type_e'(cache_req_write);

  cache_ctrl #(
    .num_lines      (num_lines),
    .words_per_line (words_per_line)
  ) ctrl0 (
    .clk, .reset, .flush, .flush_done,
    .memreq_val, .memreq_rdy, .memresp_val, .memresp_rdy,
    .cache_req_val, .cache_req_rdy, .cache_resp_val, .cache_resp_rdy,
    .tag_match, .victim_dirty, .line_dirty, .req_is_write,
    .req_en, .tag_w_en, .data_w_en, .data_w_sel, .dirty_set, .dirty_clr,
    .addr_sel, .word_cnt, .flush_line, .cache_req_write
  );

  cache_dpath #(
    .num_lines      (num_lines),
    .words_per_line (words_per_line)
  ) dpath0 (
    .clk, .reset,
    .memreq_type, .memreq_addr, .memreq_data, .cache_resp_data,
    .req_en, .tag_w_en, .data_w_en, .data_w_sel, .dirty_set, .dirty_clr,
    .addr_sel, .cache_req_write, .word_cnt, .flush_line,
    .tag_match, .victim_dirty, .line_dirty, .req_is_write,
    .memresp_data, .cache_req_addr, .cache_req_data
  );

endmodule

// File: tests/mem_model.sv
`timescale 1ns/10ps

module mem_model #(
  parameter int               depth = 128,          // words
  parameter cache_pkg::word_t fill  = '0            // xor pattern for initial content
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_val,
  output logic                 req_rdy,
  input  cache_pkg::req_type_e req_type,
  input  cache_pkg::addr_t     req_addr,
  input  cache_pkg::word_t     req_data,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output cache_pkg::word_t     resp_data
);

  localparam int aw = $clog2(depth);

  cache_pkg::word_t mem [depth];
  int req_count;                                    // every accepted request
  int wr_count;                                     // accepted writes only

  logic [aw-1:0] widx;

  assign widx    = req_addr[2 +: aw];               // word index, byte offset dropped
  assign req_rdy = !resp_val;                       // one request at a time

  // each word starts as its word address xor the fill pattern
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = cache_pkg::word_t'(i) ^ fill;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      resp_val  <= 1'b0;
      resp_data <= '0;
      req_count <= 0;
      wr_count  <= 0;
    end else if (req_val && req_rdy) begin
      resp_val  <= 1'b1;                            // answer next cycle
      req_count <= req_count + 1;
      if (req_type == cache_pkg::req_write) begin
        mem[widx] <= req_data;
        wr_count  <= wr_count + 1;
        resp_data <= '0;                            // ack only
      end else begin
        resp_data <= mem[widx];
      end
    end else if (resp_val && resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

endmodule

// File: tests/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;

  localparam int               num_lines      = 8;
  localparam int               words_per_line = 4;
  localparam int               mem_words      = 4 * num_lines * words_per_line;  // four tags
  localparam cache_pkg::word_t fill_pattern   = 32'h3c5a_96e1;

  // ========================================
  // run length limit
  // ========================================
  localparam int n_ops      = 220;                  // all accesses of all tests rounded up
  localparam int miss_cost  = 2 * words_per_line * 4 + 4;
  localparam int flush_cost = num_lines * (words_per_line * 4 + 1) + 4;
  localparam int limit      = 2 * (n_ops * miss_cost + 3 * flush_cost + 16);

  logic clk = 1'b0;
  logic reset;
  logic flush;
  logic flush_done;

  logic                 memreq_val;
  logic                 memreq_rdy;
  cache_pkg::req_type_e memreq_type;
  cache_pkg::addr_t     memreq_addr;
  cache_pkg::word_t     memreq_data;
  logic                 memresp_val;
  logic                 memresp_rdy;
  cache_pkg::word_t     memresp_data;

  logic                 cache_req_val;
  logic                 cache_req_rdy;
  cache_pkg::req_type_e cache_req_type;
  cache_pkg::addr_t     cache_req_addr;
  cache_pkg::word_t     cache_req_data;
  logic                 cache_resp_val;
  logic                 cache_resp_rdy;
  cache_pkg::word_t     cache_resp_data;

  cache_pkg::word_t shadow [mem_words];             // reference memory image
  logic [31:0]      lfsr = 32'hecf7;
  string            test_name;
  int               test_errs;                      // error count at test start
  int               errors;
  int               checks;
  int               cycles;

  always #4 clk = ~clk;                             // 8 ns period

  cache_top #(
    .num_lines      (num_lines),
    .words_per_line (words_per_line)
  ) dut0 (
    .clk, .reset, .flush, .flush_done,
    .memreq_val, .memreq_rdy, .memreq_type, .memreq_addr, .memreq_data,
    .memresp_val, .memresp_rdy, .memresp_data,
    .cache_req_val, .cache_req_rdy, .cache_req_type, .cache_req_addr, .cache_req_data,
    .cache_resp_val, .cache_resp_rdy, .cache_resp_data
  );

  mem_model #(
    .depth (mem_words),
    .fill  (fill_pattern)
  ) mem0 (
    .clk, .reset,
    .req_val   (cache_req_val),
    .req_rdy   (cache_req_rdy),
    .req_type  (cache_req_type),
    .req_addr  (cache_req_addr),
    .req_data  (cache_req_data),
    .resp_val  (cache_resp_val),
    .resp_rdy  (cache_resp_rdy),
    .resp_data (cache_resp_data)
  );

  // ========================================
  // helpers
  // ========================================
  // x^32 + x^22 + x^2 + x + 1 shifting left
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);                       // one step per bit
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic cache_pkg::addr_t make_addr(input int tag, input int idx, input int wrd);
    return cache_pkg::addr_t'(((tag * num_lines + idx) * words_per_line + wrd) * 4);
  endfunction

  function automatic int word_index(input cache_pkg::addr_t a);
    return int'(a >> 2);
  endfunction

  function automatic cache_pkg::word_t fill_word(input int widx);
    return cache_pkg::word_t'(widx) ^ fill_pattern;  // initial memory rule
  endfunction

  task automatic check_word(input string what, input cache_pkg::word_t exp,
                            input cache_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic finish_test();
    $display("%s finished, %0d errors", test_name, errors - test_errs);
  endtask

  // ========================================
  // processor port and flush drivers
  // ========================================
  // called just after a rising edge and returns on the accept edge
  task automatic send_req(input cache_pkg::req_type_e kind, input cache_pkg::addr_t addr,
                          input cache_pkg::word_t data);
    memreq_val  <= 1'b1;
    memreq_type <= kind;
    memreq_addr <= addr;
    memreq_data <= data;
    do @(posedge clk); while (!memreq_rdy);
    memreq_val <= 1'b0;
  endtask

  task automatic wait_resp(output cache_pkg::word_t data, output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;                                        // edges since acceptance
    end while (!(memresp_val && memresp_rdy));
    data = memresp_data;
  endtask

  task automatic access(input cache_pkg::req_type_e kind, input cache_pkg::addr_t addr,
                        input cache_pkg::word_t wdata, output cache_pkg::word_t rdata,
                        output int lat);
    send_req(kind, addr, wdata);
    wait_resp(rdata, lat);
    if (kind == cache_pkg::req_write) shadow[word_index(addr)] = wdata;
  endtask

  task automatic run_flush();
    flush <= 1'b1;
    do @(posedge clk); while (!flush_done);
    flush <= 1'b0;
    @(posedge clk);
    check_flag("flush_done held one cycle", 1'b1, flush_done);
    @(posedge clk);
    check_flag("flush_done dropped", 1'b0, flush_done);
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic read_miss_then_hit();
    cache_pkg::word_t rdata;
    int lat;
    start_test("read_miss_then_hit");
    access(cache_pkg::req_read, make_addr(1, 2, 1), '0, rdata, lat);
    check_word("cold read", fill_word(word_index(make_addr(1, 2, 1))), rdata);
    access(cache_pkg::req_read, make_addr(1, 2, 2), '0, rdata, lat);
    check_word("hit read", fill_word(word_index(make_addr(1, 2, 2))), rdata);
    check_flag("hit answered next cycle", 1'b1, lat == 1);
    finish_test();
  endtask

  task automatic write_hit_readback();
    cache_pkg::word_t wdata;
    cache_pkg::word_t rdata;
    int lat;
    int wr0;
    start_test("write_hit_readback");
    wr0   = mem0.wr_count;
    wdata = take_bits(32);
    access(cache_pkg::req_write, make_addr(1, 2, 3), wdata, rdata, lat);
    access(cache_pkg::req_read, make_addr(1, 2, 3), '0, rdata, lat);
    check_word("readback", wdata, rdata);
    check_flag("no memory write on hit", 1'b1, mem0.wr_count == wr0);
    finish_test();
  endtask

  task automatic dirty_evict();
    cache_pkg::word_t wdata;
    cache_pkg::word_t rdata;
    int lat;
    start_test("dirty_evict");
    wdata = take_bits(32);
    access(cache_pkg::req_write, make_addr(0, 3, 0), wdata, rdata, lat);
    access(cache_pkg::req_read, make_addr(2, 3, 0), '0, rdata, lat);  // same index with a new tag
    check_word("read of new tag", fill_word(word_index(make_addr(2, 3, 0))), rdata);
    check_word("victim word in memory", wdata, mem0.mem[word_index(make_addr(0, 3, 0))]);
    access(cache_pkg::req_read, make_addr(0, 3, 0), '0, rdata, lat);
    check_word("reread of evicted word", wdata, rdata);
    finish_test();
  endtask

  task automatic resp_backpressure();
    cache_pkg::word_t held;
    cache_pkg::word_t rdata;
    int lat;
    start_test("resp_backpressure");
    memresp_rdy <= 1'b0;
    send_req(cache_pkg::req_read, make_addr(0, 3, 0), '0);  // resident line
    @(posedge clk);
    check_flag("memresp_val after hit", 1'b1, memresp_val);
    held = memresp_data;
    repeat (5) begin
      @(posedge clk);
      check_flag("memresp_val held", 1'b1, memresp_val);
      check_flag("memreq_rdy low while held", 1'b0, memreq_rdy);
      check_word("memresp_data held", held, memresp_data);
    end
    memresp_rdy <= 1'b1;
    wait_resp(rdata, lat);
    check_word("read under back-pressure", shadow[word_index(make_addr(0, 3, 0))], rdata);
    finish_test();
  endtask

  task automatic flush_writeback();
    cache_pkg::word_t wdata;
    cache_pkg::word_t rdata;
    int lat;
    int rc0;
    start_test("flush_writeback");
    wdata = take_bits(32);
    access(cache_pkg::req_write, make_addr(0, 0, 1), wdata, rdata, lat);
    wdata = take_bits(32);
    access(cache_pkg::req_write, make_addr(0, 5, 2), wdata, rdata, lat);
    wdata = take_bits(32);
    access(cache_pkg::req_write, make_addr(3, 6, 3), wdata, rdata, lat);
    run_flush();
    for (int i = 0; i < mem_words; i++) begin
      check_word("memory after flush", shadow[i], mem0.mem[i]);  // all dirty data written back
    end
    rc0 = mem0.req_count;
    run_flush();
    check_flag("no memory requests on clean flush", 1'b1, mem0.req_count == rc0);
    access(cache_pkg::req_read, make_addr(3, 6, 3), '0, rdata, lat);
    check_word("read after flush", shadow[word_index(make_addr(3, 6, 3))], rdata);
    check_flag("line still valid after flush", 1'b1, lat == 1);
    finish_test();
  endtask

  task automatic random_mix();
    cache_pkg::req_type_e kind;
    cache_pkg::addr_t     addr;
    cache_pkg::word_t     wdata;
    cache_pkg::word_t     rdata;
    int lat;
    int tag;
    int idx;
    int wrd;
    start_test("random_mix");
    for (int i = 0; i < 200; i++) begin
      kind  = take_bits(1) ? cache_pkg::req_write : cache_pkg::req_read;
      tag   = take_bits(2);
      idx   = take_bits($clog2(num_lines));
      wrd   = take_bits($clog2(words_per_line));
      addr  = make_addr(tag, idx, wrd);
      wdata = (kind == cache_pkg::req_write) ? take_bits(32) : '0;
      access(kind, addr, wdata, rdata, lat);
      if (kind == cache_pkg::req_read) check_word("random read", shadow[word_index(addr)], rdata);
    end
    finish_test();
  endtask

  // ========================================
  // run control
  // ========================================
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, controller stuck in state %s",
               cycles, dut0.ctrl0.state.name());
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    reset       <= 1'b1;
    flush       <= 1'b0;
    memreq_val  <= 1'b0;
    memreq_type <= cache_pkg::req_read;
    memreq_addr <= '0;
    memreq_data <= '0;
    memresp_rdy <= 1'b1;
    for (int i = 0; i < mem_words; i++) shadow[i] = fill_word(i);
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    read_miss_then_hit();
    write_hit_readback();
    dirty_evict();
    resp_backpressure();
    flush_writeback();
    random_mix();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: all.f
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/cache_dpath.sv
rtl/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv
